// File: source/tlp_pkg.sv
`default_nettype none

package tlp_pkg;

	localparam int TLP_WORD_W = 16;

	typedef logic [TLP_WORD_W-1:0] tlp_word_t;
	typedef logic [9:0]            tlp_len_t;
	typedef logic [3:0]            tlp_be_t;
	typedef logic [11:0]           tlp_byte_cnt_t;

	// Packet kind, decoded from the type field of header word 0
	typedef enum logic [2:0] {
		KIND_MEM      = 3'h0,
		KIND_MEM_LOCK = 3'h1,
		KIND_IO       = 3'h2,
		KIND_CFG0     = 3'h3,
		KIND_CFG1     = 3'h4,
		KIND_MSG      = 3'h5,
		KIND_CPL      = 3'h6,
		KIND_CPL_LOCK = 3'h7
	} tlp_kind_e;

	// Header word 0
	typedef struct packed {
		logic       rsvd_a;
		logic [1:0] fmt;
		logic [4:0] typ;
		logic       rsvd_b;
		logic [2:0] tc;
		logic [3:0] rsvd_c;
	} tlp_hdr0_t;

	// Header word 1
	typedef struct packed {
		logic       td;
		logic       ep;
		logic [1:0] attr;
		logic [1:0] rsvd;
		tlp_len_t   length;
	} tlp_hdr1_t;

	typedef union packed {
		tlp_hdr0_t h0;
		tlp_hdr1_t h1;
	} tlp_word_u;

	// Completion with data, 3DW header
	localparam logic [1:0] FMT_3DW_DATA = 2'b10;
	localparam logic [4:0] TYPE_CPL     = 5'b01010;

endpackage

`default_nettype wire

// File: source/tlp_rx_if.sv
`default_nettype none

interface tlp_rx_if;

	tlp_pkg::tlp_kind_e kind;
	logic               is_write;
	logic               has_data;
	logic               is_4dw;
	tlp_pkg::tlp_len_t  length;
	logic [15:0]        reqid;
	logic [7:0]         tag;
	tlp_pkg::tlp_be_t   first_be;
	tlp_pkg::tlp_be_t   last_be;
	logic [63:2]        addr;
	logic               hdr_valid;
	logic               pay_valid;
	tlp_pkg::tlp_word_t pay_data;
	logic               pkt_end;
	logic [6:0]         bar_hit;

	modport parser (
		output kind, is_write, has_data, is_4dw, length, reqid, tag, first_be, last_be,
		output addr, hdr_valid, pay_valid, pay_data, pkt_end, bar_hit
	);

	modport credit (
		input kind, is_write, has_data, length, pkt_end, bar_hit
	);

	modport seq (
		input kind, is_write, length, reqid, tag, first_be, last_be, addr,
		input hdr_valid, pay_valid, pay_data, pkt_end, bar_hit
	);

endinterface

`default_nettype wire

// File: source/tlp_cpl_if.sv
`default_nettype none

interface tlp_cpl_if;

	logic                   cpl_valid;
	tlp_pkg::tlp_len_t      length;
	tlp_pkg::tlp_byte_cnt_t byte_cnt;
	logic [15:0]            reqid;
	logic [7:0]             tag;
	logic [6:0]             low_addr;
	logic                   rd_req;
	tlp_pkg::tlp_word_t     rd_data;

	modport seq (
		output cpl_valid, length, byte_cnt, reqid, tag, low_addr, rd_data,
		input  rd_req
	);

	modport tx (
		input  cpl_valid, length, byte_cnt, reqid, tag, low_addr, rd_data,
		output rd_req
	);

endinterface

`default_nettype wire

// File: source/tlp_rx_parser.sv
`default_nettype none

module tlp_rx_parser (
	input  logic               pcie_clk,
	input  logic               sys_rst,
	input  logic               rx_st_i,
	input  logic               rx_end_i,
	input  tlp_pkg::tlp_word_t rx_data_i,
	input  logic [6:0]         rx_bar_hit_i,
	tlp_rx_if.parser           rx
);

	localparam logic [3:0]
		ST_HEAD0 = 4'h0,
		ST_HEAD1 = 4'h1,
		ST_REQ2  = 4'h2,
		ST_REQ3  = 4'h3,
		ST_REQ4  = 4'h4,
		ST_REQ5  = 4'h5,
		ST_REQ6  = 4'h6,
		ST_REQ7  = 4'h7,
		ST_CPL2  = 4'h8,
		ST_CPL3  = 4'h9,
		ST_CPL4  = 4'ha,
		ST_CPL5  = 4'hb,
		ST_DATA  = 4'hc;

	logic [3:0]         state;
	tlp_pkg::tlp_word_u hdr_word;
	tlp_pkg::tlp_kind_e kind_dec;

	assign hdr_word = rx_data_i;

	always_comb begin
		if (hdr_word.h0.typ[4]) begin
			kind_dec = tlp_pkg::KIND_MSG;
		end else if (!hdr_word.h0.typ[3]) begin
			case (hdr_word.h0.typ[2:0])
				3'b000:  kind_dec = tlp_pkg::KIND_MEM;
				3'b001:  kind_dec = tlp_pkg::KIND_MEM_LOCK;
				3'b010:  kind_dec = tlp_pkg::KIND_IO;
				3'b100:  kind_dec = tlp_pkg::KIND_CFG0;
				default: kind_dec = tlp_pkg::KIND_CFG1;
			endcase
		end else if (hdr_word.h0.typ[0]) begin
			kind_dec = tlp_pkg::KIND_CPL_LOCK;
		end else begin
			kind_dec = tlp_pkg::KIND_CPL;
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= ST_HEAD0;
			rx.hdr_valid <= 1'b0;
			rx.pay_valid <= 1'b0;
			rx.pkt_end <= 1'b0;
		end else begin
			rx.hdr_valid <= 1'b0;
			rx.pay_valid <= 1'b0;
			rx.pkt_end <= rx_end_i;
			case (state)
				ST_HEAD0: begin
					if (rx_st_i) begin
						rx.kind <= kind_dec;
						rx.has_data <= hdr_word.h0.fmt[1];
						rx.is_4dw <= hdr_word.h0.fmt[0];
						rx.is_write <= hdr_word.h0.fmt[1] && (hdr_word.h0.typ[4:1] == 4'b0000);
						rx.bar_hit <= rx_bar_hit_i;
						state <= ST_HEAD1;
					end
				end
				ST_HEAD1: begin
					rx.length <= hdr_word.h1.length;
					if (rx.kind == tlp_pkg::KIND_CPL || rx.kind == tlp_pkg::KIND_CPL_LOCK) begin
						state <= ST_CPL2;
					end else begin
						state <= ST_REQ2;
					end
				end
				ST_REQ2: begin
					rx.reqid <= rx_data_i;
					state <= ST_REQ3;
				end
				ST_REQ3: begin
					rx.tag <= rx_data_i[15:8];
					rx.last_be <= rx_data_i[7:4];
					rx.first_be <= rx_data_i[3:0];
					// 3DW header has no upper address words
					if (rx.is_4dw) begin
						state <= ST_REQ4;
					end else begin
						rx.addr[63:32] <= '0;
						state <= ST_REQ6;
					end
				end
				ST_REQ4: begin
					rx.addr[63:48] <= rx_data_i;
					state <= ST_REQ5;
				end
				ST_REQ5: begin
					rx.addr[47:32] <= rx_data_i;
					state <= ST_REQ6;
				end
				ST_REQ6: begin
					rx.addr[31:16] <= rx_data_i;
					state <= ST_REQ7;
				end
				ST_REQ7: begin
					rx.addr[15:2] <= rx_data_i[15:2];
					rx.hdr_valid <= 1'b1;
					state <= ST_DATA;
				end
				// Completion header is walked but not decoded
				ST_CPL2, ST_CPL3, ST_CPL4, ST_CPL5: begin
					state <= state + 4'h1;
				end
				ST_DATA: begin
					rx.pay_valid <= 1'b1;
					rx.pay_data <= rx_data_i;
				end
				default: begin
					state <= ST_HEAD0;
				end
			endcase
			if (rx_end_i) begin
				state <= ST_HEAD0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/rx_credit_return.sv
`default_nettype none

module rx_credit_return (
	input  logic       pcie_clk,
	input  logic       sys_rst,
	tlp_rx_if.credit   rx,
	output logic       ph_cr_o,
	output logic       pd_cr_o,
	output logic       nph_cr_o,
	output logic       npd_cr_o,
	output logic [7:0] pd_num_o
);

	logic [7:0] pd_units;

	// Length in units of four doublewords, rounded up
	assign pd_units = rx.length[9:2] + {7'h0, |rx.length[1:0]};

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			ph_cr_o <= 1'b0;
			pd_cr_o <= 1'b0;
			nph_cr_o <= 1'b0;
			npd_cr_o <= 1'b0;
			pd_num_o <= 8'h0;
		end else begin
			ph_cr_o <= 1'b0;
			pd_cr_o <= 1'b0;
			nph_cr_o <= 1'b0;
			npd_cr_o <= 1'b0;
			pd_num_o <= 8'h0;
			if (rx.pkt_end) begin
				case (rx.kind)
					tlp_pkg::KIND_MEM, tlp_pkg::KIND_MEM_LOCK: begin
						if (rx.bar_hit != 7'h0) begin
							ph_cr_o <= rx.is_write;
							pd_cr_o <= rx.is_write;
							nph_cr_o <= !rx.is_write;
							pd_num_o <= rx.is_write ? pd_units : 8'h0;
						end
					end
					tlp_pkg::KIND_IO, tlp_pkg::KIND_CFG0, tlp_pkg::KIND_CFG1: begin
						nph_cr_o <= 1'b1;
						npd_cr_o <= rx.has_data;
					end
					tlp_pkg::KIND_MSG: begin
						ph_cr_o <= 1'b1;
						pd_cr_o <= rx.has_data;
						pd_num_o <= rx.has_data ? pd_units : 8'h0;
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: source/slave_sequencer.sv
`default_nettype none

module slave_sequencer #(
	parameter int SLV_ADDR_W = 19
) (
	input  logic                  pcie_clk,
	input  logic                  sys_rst,
	tlp_rx_if.seq                 rx,
	tlp_cpl_if.seq                cpl,
	output logic [6:0]            slv_bar_o,
	output logic                  slv_ce_o,
	output logic                  slv_we_o,
	output logic [SLV_ADDR_W-1:0] slv_adr_o,
	output tlp_pkg::tlp_word_t    slv_dat_o,
	output logic [1:0]            slv_sel_o,
	input  tlp_pkg::tlp_word_t    slv_dat_i
);

	localparam logic [1:0]
		SEQ_IDLE  = 2'h0,
		SEQ_WRITE = 2'h1,
		SEQ_READ  = 2'h2;

	logic [1:0]             state;
	logic [10:0]            word_cnt;
	logic                   accept;
	logic [SLV_ADDR_W-1:0]  start_adr;
	tlp_pkg::tlp_byte_cnt_t byte_cnt;
	logic [1:0]             sel;

	function automatic logic [1:0] low_bit(input tlp_pkg::tlp_be_t be);
		logic [1:0] idx;
		idx = 2'd0;
		for (int i = 3; i >= 0; i--) begin
			if (be[i]) begin
				idx = 2'(i);
			end
		end
		return idx;
	endfunction

	function automatic logic [1:0] high_bit(input tlp_pkg::tlp_be_t be);
		logic [1:0] idx;
		idx = 2'd0;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				idx = 2'(i);
			end
		end
		return idx;
	endfunction

	assign accept = rx.hdr_valid && (rx.kind == tlp_pkg::KIND_MEM) && (rx.bar_hit != 7'h0);

	// One below the first halfword, the address steps before every access
	assign start_adr = {rx.addr[SLV_ADDR_W:2], 1'b0} - SLV_ADDR_W'(1);

	always_comb begin
		if (rx.length == 10'd1 && rx.last_be == 4'h0) begin
			if (rx.first_be == 4'h0) begin
				byte_cnt = 12'd1;
			end else begin
				byte_cnt = 12'(high_bit(rx.first_be)) - 12'(low_bit(rx.first_be)) + 12'd1;
			end
		end else begin
			byte_cnt = {rx.length, 2'b00} - 12'(low_bit(rx.first_be))
				- 12'(2'd3 - high_bit(rx.last_be));
		end
	end

	// Byte lanes of the halfword at word_cnt
	always_comb begin
		if (word_cnt[10:1] == 10'h0) begin
			sel = word_cnt[0] ? {rx.first_be[2], rx.first_be[3]} : {rx.first_be[0], rx.first_be[1]};
		end else if (word_cnt[10:1] == rx.length - 10'h1) begin
			sel = word_cnt[0] ? {rx.last_be[2], rx.last_be[3]} : {rx.last_be[0], rx.last_be[1]};
		end else begin
			sel = 2'b11;
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= SEQ_IDLE;
			slv_bar_o <= 7'h0;
			slv_ce_o <= 1'b0;
			slv_we_o <= 1'b0;
			cpl.cpl_valid <= 1'b0;
		end else begin
			slv_ce_o <= 1'b0;
			slv_we_o <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					slv_bar_o <= 7'h0;
					if (accept) begin
						slv_bar_o <= rx.bar_hit;
						slv_adr_o <= start_adr;
						if (rx.is_write) begin
							word_cnt <= 11'h0;
							state <= SEQ_WRITE;
						end else begin
							word_cnt <= {rx.length, 1'b0};
							cpl.cpl_valid <= 1'b1;
							cpl.length <= rx.length;
							cpl.byte_cnt <= byte_cnt;
							cpl.reqid <= rx.reqid;
							cpl.tag <= rx.tag;
							cpl.low_addr <= {rx.addr[6:2], low_bit(rx.first_be)};
							state <= SEQ_READ;
						end
					end
				end
				//--------------------------------------------------------------------------
				// Memory write, one slave cycle per payload word
				//--------------------------------------------------------------------------
				SEQ_WRITE: begin
					if (rx.pay_valid) begin
						slv_ce_o <= 1'b1;
						slv_we_o <= 1'b1;
						slv_adr_o <= slv_adr_o + SLV_ADDR_W'(1);
						slv_dat_o <= rx.pay_data;
						slv_sel_o <= sel;
						word_cnt <= word_cnt + 11'h1;
					end
					if (rx.pkt_end) begin
						state <= SEQ_IDLE;
					end
				end
				//--------------------------------------------------------------------------
				// Memory read, halfwords fetched on request of the transmitter
				//--------------------------------------------------------------------------
				SEQ_READ: begin
					if (cpl.rd_req) begin
						slv_ce_o <= 1'b1;
						slv_sel_o <= 2'b11;
						slv_adr_o <= slv_adr_o + SLV_ADDR_W'(1);
						word_cnt <= word_cnt - 11'h1;
					end
					// Slave data comes back the cycle after the strobe
					if (slv_ce_o) begin
						cpl.rd_data <= slv_dat_i;
						if (word_cnt == 11'h0) begin
							cpl.cpl_valid <= 1'b0;
							state <= SEQ_IDLE;
						end
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/cpl_transmitter.sv
`default_nettype none

module cpl_transmitter (
	input  logic               pcie_clk,
	input  logic               sys_rst,
	tlp_cpl_if.tx              cpl,
	input  logic [7:0]         bus_num_i,
	input  logic [4:0]         dev_num_i,
	input  logic [2:0]         func_num_i,
	output logic               tx_req_o,
	input  logic               tx_rdy_i,
	output logic               tx_st_o,
	output logic               tx_end_o,
	output tlp_pkg::tlp_word_t tx_data_o
);

	localparam logic [1:0]
		TX_IDLE = 2'h0,
		TX_WAIT = 2'h1,
		TX_SEND = 2'h2;

	logic [1:0]         state;
	logic [11:0]        slot;
	logic [11:0]        last_slot;
	tlp_pkg::tlp_word_u hdr0;
	tlp_pkg::tlp_word_u hdr1;

	// Six header words then 2 x length data words
	assign last_slot = {1'b0, cpl.length, 1'b0} + 12'd5;

	always_comb begin
		hdr0 = '0;
		hdr0.h0.fmt = tlp_pkg::FMT_3DW_DATA;
		hdr0.h0.typ = tlp_pkg::TYPE_CPL;
		hdr1 = '0;
		hdr1.h1.length = cpl.length;
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= TX_IDLE;
			tx_req_o <= 1'b0;
			tx_st_o <= 1'b0;
			tx_end_o <= 1'b0;
			cpl.rd_req <= 1'b0;
		end else begin
			tx_st_o <= 1'b0;
			tx_end_o <= 1'b0;
			cpl.rd_req <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (cpl.cpl_valid) begin
						tx_req_o <= 1'b1;
						state <= TX_WAIT;
					end
				end
				TX_WAIT: begin
					if (tx_rdy_i) begin
						tx_req_o <= 1'b0;
						tx_st_o <= 1'b1;
						tx_data_o <= hdr0;
						slot <= 12'd1;
						state <= TX_SEND;
					end
				end
				TX_SEND: begin
					slot <= slot + 12'd1;
					// Read data lands two cycles after its request
					cpl.rd_req <= (slot >= 12'd3) && (slot + 12'd2 < last_slot);
					case (slot)
						12'd1:   tx_data_o <= hdr1;
						12'd2:   tx_data_o <= {bus_num_i, dev_num_i, func_num_i};
						12'd3:   tx_data_o <= {3'b000, 1'b0, cpl.byte_cnt};
						12'd4:   tx_data_o <= cpl.reqid;
						12'd5:   tx_data_o <= {cpl.tag, 1'b0, cpl.low_addr};
						default: tx_data_o <= cpl.rd_data;
					endcase
					if (slot == last_slot) begin
						tx_end_o <= 1'b1;
						state <= TX_IDLE;
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/pcie_tlp.sv
`default_nettype none

module pcie_tlp #(
	parameter int SLV_ADDR_W = 19
) (
	input  logic                  pcie_clk,
	input  logic                  sys_rst,
	// Receive stream
	input  logic                  rx_st_i,
	input  logic                  rx_end_i,
	input  tlp_pkg::tlp_word_t    rx_data_i,
	input  logic [6:0]            rx_bar_hit_i,
	input  logic [7:0]            bus_num_i,
	input  logic [4:0]            dev_num_i,
	input  logic [2:0]            func_num_i,
	// Transmit stream
	output logic                  tx_req_o,
	input  logic                  tx_rdy_i,
	output logic                  tx_st_o,
	output logic                  tx_end_o,
	output tlp_pkg::tlp_word_t    tx_data_o,
	// Receive credits
	output logic                  ph_cr_o,
	output logic                  pd_cr_o,
	output logic                  nph_cr_o,
	output logic                  npd_cr_o,
	output logic [7:0]            pd_num_o,
	// Slave bus
	output logic [6:0]            slv_bar_o,
	output logic                  slv_ce_o,
	output logic                  slv_we_o,
	output logic [SLV_ADDR_W-1:0] slv_adr_o,
	output tlp_pkg::tlp_word_t    slv_dat_o,
	output logic [1:0]            slv_sel_o,
	input  tlp_pkg::tlp_word_t    slv_dat_i
);

	tlp_rx_if  rx();
	tlp_cpl_if cpl();

	tlp_rx_parser i_rx_parser (
		.pcie_clk, .sys_rst,
		.rx_st_i, .rx_end_i, .rx_data_i, .rx_bar_hit_i,
		.rx(rx.parser)
	);

	rx_credit_return i_rx_credit_return (
		.pcie_clk, .sys_rst,
		.rx(rx.credit),
		.ph_cr_o, .pd_cr_o, .nph_cr_o, .npd_cr_o, .pd_num_o
	);

	slave_sequencer #(
		.SLV_ADDR_W(SLV_ADDR_W)
	) i_slave_sequencer (
		.pcie_clk, .sys_rst,
		.rx(rx.seq), .cpl(cpl.seq),
		.slv_bar_o, .slv_ce_o, .slv_we_o, .slv_adr_o,
		.slv_dat_o, .slv_sel_o, .slv_dat_i
	);

	cpl_transmitter i_cpl_transmitter (
		.pcie_clk, .sys_rst,
		.cpl(cpl.tx),
		.bus_num_i, .dev_num_i, .func_num_i,
		.tx_req_o, .tx_rdy_i, .tx_st_o, .tx_end_o, .tx_data_o
	);

endmodule

`default_nettype wire

// File: tb/pcie_tlp_assertions.sv
`default_nettype none

module pcie_tlp_assertions (
	input logic pcie_clk,
	input logic sys_rst,
	input logic tx_req_o,
	input logic tx_st_o,
	input logic slv_ce_o,
	input logic slv_we_o,
	input logic ph_cr_o,
	input logic pd_cr_o,
	input logic nph_cr_o,
	input logic npd_cr_o
);

	int   fail_cnt = 0;
	logic rst_q;

	// Reset seen on the previous edge as well, so outputs are settled
	always @(posedge pcie_clk) begin
		rst_q <= sys_rst;
	end

	st_without_req: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		!(tx_st_o && tx_req_o))
	else begin
		fail_cnt++;
		$error("tx_st_o high together with tx_req_o");
	end

	we_needs_ce: assert property (@(posedge pcie_clk) disable iff (sys_rst)
		slv_we_o |-> slv_ce_o)
	else begin
		fail_cnt++;
		$error("slv_we_o high without slv_ce_o");
	end

	no_credit_in_reset: assert property (@(posedge pcie_clk)
		(sys_rst && rst_q) |-> !(ph_cr_o || pd_cr_o || nph_cr_o || npd_cr_o))
	else begin
		fail_cnt++;
		$error("credit pulse during reset");
	end

endmodule

bind pcie_tlp pcie_tlp_assertions i_pcie_tlp_assertions (
	.pcie_clk(pcie_clk),
	.sys_rst(sys_rst),
	.tx_req_o(tx_req_o),
	.tx_st_o(tx_st_o),
	.slv_ce_o(slv_ce_o),
	.slv_we_o(slv_we_o),
	.ph_cr_o(ph_cr_o),
	.pd_cr_o(pd_cr_o),
	.nph_cr_o(nph_cr_o),
	.npd_cr_o(npd_cr_o)
);

`default_nettype wire

// File: tb/tb_pcie_tlp.sv
`default_nettype none

module tb_pcie_tlp;

	localparam int SLV_ADDR_W  = 19;
	localparam int CLK_PERIOD  = 20;
	localparam int DRV         = 2;
	localparam int NUM_TESTS   = 5;
	localparam int TEST_CYCLES = 200;

	localparam int EV_CREDIT  = 0;
	localparam int EV_WRITES  = 1;
	localparam int EV_TX_REQ  = 2;
	localparam int EV_TX_DONE = 3;

	logic                  pcie_clk;
	logic                  sys_rst;
	logic                  rx_st_i;
	logic                  rx_end_i;
	tlp_pkg::tlp_word_t    rx_data_i;
	logic [6:0]            rx_bar_hit_i;
	logic [7:0]            bus_num_i;
	logic [4:0]            dev_num_i;
	logic [2:0]            func_num_i;
	logic                  tx_req_o;
	logic                  tx_rdy_i;
	logic                  tx_st_o;
	logic                  tx_end_o;
	tlp_pkg::tlp_word_t    tx_data_o;
	logic                  ph_cr_o;
	logic                  pd_cr_o;
	logic                  nph_cr_o;
	logic                  npd_cr_o;
	logic [7:0]            pd_num_o;
	logic [6:0]            slv_bar_o;
	logic                  slv_ce_o;
	logic                  slv_we_o;
	logic [SLV_ADDR_W-1:0] slv_adr_o;
	tlp_pkg::tlp_word_t    slv_dat_o;
	logic [1:0]            slv_sel_o;
	tlp_pkg::tlp_word_t    slv_dat_i;

	tlp_pkg::tlp_word_t    pkt [0:31];
	int                    err_cnt;
	integer                seed;
	int                    ph_cnt;
	int                    pd_cnt;
	int                    nph_cnt;
	int                    npd_cnt;
	logic [7:0]            pd_num_seen;
	logic [SLV_ADDR_W-1:0] wr_adr [$];
	tlp_pkg::tlp_word_t    wr_dat [$];
	logic [1:0]            wr_sel [$];
	logic [6:0]            wr_bar [$];
	// Transmitted words as {st, end, data}
	logic [17:0]           tx_log [$];
	logic                  tx_busy;
	int                    tx_done;

	pcie_tlp #(
		.SLV_ADDR_W(SLV_ADDR_W)
	) i_pcie_tlp (.*);

	initial begin
		pcie_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;
	end

	// ------------------------------------------------------------------------
	// Slave memory model and monitors
	// ------------------------------------------------------------------------
	function automatic tlp_pkg::tlp_word_t model_data(input logic [SLV_ADDR_W-1:0] adr);
		return adr[15:0] ^ {adr[18:16], 13'h0} ^ 16'hc35a;
	endfunction

	always @(posedge pcie_clk) begin
		#DRV;
		if (!$isunknown(slv_adr_o)) begin
			slv_dat_i = model_data(slv_adr_o);
		end
	end

	always @(posedge pcie_clk) begin
		if (!sys_rst) begin
			ph_cnt += int'(ph_cr_o);
			pd_cnt += int'(pd_cr_o);
			nph_cnt += int'(nph_cr_o);
			npd_cnt += int'(npd_cr_o);
			if (ph_cr_o || pd_cr_o || nph_cr_o || npd_cr_o) begin
				pd_num_seen = pd_num_o;
			end
			if (slv_ce_o && slv_we_o) begin
				wr_adr.push_back(slv_adr_o);
				wr_dat.push_back(slv_dat_o);
				wr_sel.push_back(slv_sel_o);
				wr_bar.push_back(slv_bar_o);
			end
			if (tx_st_o) begin
				tx_busy = 1'b1;
			end
			if (tx_busy) begin
				tx_log.push_back({tx_st_o, tx_end_o, tx_data_o});
			end
			if (tx_end_o) begin
				tx_busy = 1'b0;
				tx_done++;
			end
		end
	end

	task automatic clear_monitors();
		ph_cnt = 0;
		pd_cnt = 0;
		nph_cnt = 0;
		npd_cnt = 0;
		pd_num_seen = 8'h0;
		wr_adr.delete();
		wr_dat.delete();
		wr_sel.delete();
		wr_bar.delete();
		tx_log.delete();
		tx_busy = 1'b0;
		tx_done = 0;
	endtask

	// ------------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------------
	task automatic check_word(input string name, input tlp_pkg::tlp_word_t got,
		input tlp_pkg::tlp_word_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input tlp_pkg::tlp_byte_cnt_t got,
		input tlp_pkg::tlp_byte_cnt_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_credits(input int ph, input int pd, input int nph, input int npd,
		input int pd_num);
		check_count("ph_cr_o pulses", 12'(ph_cnt), 12'(ph));
		check_count("pd_cr_o pulses", 12'(pd_cnt), 12'(pd));
		check_count("nph_cr_o pulses", 12'(nph_cnt), 12'(nph));
		check_count("npd_cr_o pulses", 12'(npd_cnt), 12'(npd));
		check_count("pd_num_o", 12'(pd_num_seen), 12'(pd_num));
	endtask

	task automatic check_completion(input logic [15:0] reqid, input logic [7:0] tag,
		input tlp_pkg::tlp_len_t len, input tlp_pkg::tlp_byte_cnt_t byte_cnt,
		input logic [6:0] low_addr, input logic [SLV_ADDR_W-1:0] base);
		tlp_pkg::tlp_word_t hdr [0:5];
		tlp_pkg::tlp_word_t exp;
		int n;
		// Completion with data is fmt 10 and type 01010
		hdr[0] = 16'h4a00;
		hdr[1] = {6'h0, len};
		hdr[2] = {bus_num_i, dev_num_i, func_num_i};
		hdr[3] = {4'h0, byte_cnt};
		hdr[4] = reqid;
		hdr[5] = {tag, 1'b0, low_addr};
		n = 6 + 2 * int'(len);
		check_count("completion length in words", 12'(tx_log.size()), 12'(n));
		for (int i = 0; i < n && i < tx_log.size(); i++) begin
			exp = (i < 6) ? hdr[i] : model_data(base + SLV_ADDR_W'(i - 6));
			check_word($sformatf("tx_data_o word %0d", i), tx_log[i][15:0], exp);
			check_bit($sformatf("tx_st_o word %0d", i), tx_log[i][17], i == 0);
			check_bit($sformatf("tx_end_o word %0d", i), tx_log[i][16], i == n - 1);
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------------
	task automatic send_packet(input int n, input logic [6:0] bar);
		for (int i = 0; i < n; i++) begin
			@(posedge pcie_clk);
			#DRV;
			rx_st_i = (i == 0);
			rx_end_i = (i == n - 1);
			rx_data_i = pkt[i];
			rx_bar_hit_i = bar;
		end
		@(posedge pcie_clk);
		#DRV;
		rx_st_i = 1'b0;
		rx_end_i = 1'b0;
		rx_data_i = '0;
		rx_bar_hit_i = 7'h0;
	endtask

	function automatic bit event_seen(input int ev, input int n);
		case (ev)
			EV_CREDIT:  return (ph_cnt + pd_cnt + nph_cnt + npd_cnt) > 0;
			EV_WRITES:  return wr_adr.size() >= n;
			EV_TX_REQ:  return tx_req_o === 1'b1;
			default:    return tx_done >= n;
		endcase
	endfunction

	task automatic await_event(input int ev, input int n, input string what);
		int cyc;
		cyc = 0;
		while (!event_seen(ev, n) && cyc < 40) begin
			@(posedge pcie_clk);
			#DRV;
			cyc++;
		end
		if (!event_seen(ev, n)) begin
			err_cnt++;
			$display("timeout while waiting for %s", what);
		end
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic test_msg_cfg_credits();
		clear_monitors();
		// Message with data and 4DW header of length 5
		pkt[0] = 16'h7000;
		pkt[1] = 16'h0005;
		pkt[2] = 16'h0100;
		pkt[3] = 16'h0700;
		for (int i = 4; i < 8; i++) begin
			pkt[i] = 16'h0;
		end
		for (int i = 8; i < 18; i++) begin
			pkt[i] = 16'h1000 + 16'(i);
		end
		send_packet(18, 7'h0);
		await_event(EV_CREDIT, 0, "message credits");
		check_credits(1, 1, 0, 0, 2);
		clear_monitors();
		// cfg0 write of length 1
		pkt[0] = 16'h4400;
		pkt[1] = 16'h0001;
		pkt[2] = 16'h0100;
		pkt[3] = 16'h080f;
		pkt[4] = 16'h0328;
		pkt[5] = 16'h0010;
		pkt[6] = 16'hcafe;
		pkt[7] = 16'hf00d;
		send_packet(8, 7'h0);
		await_event(EV_CREDIT, 0, "cfg0 credits");
		check_credits(0, 0, 1, 1, 0);
		check_count("slave writes", 12'(wr_adr.size()), 12'd0);
	endtask

	task automatic test_mem_write();
		logic [31:0]           addr;
		logic [SLV_ADDR_W-1:0] base;
		// Select lanes for first_be 1110 and last_be 0011
		logic [1:0]            exp_sel [0:3];
		addr = 32'h0003_4568;
		base = {addr[19:2], 1'b0};
		exp_sel[0] = 2'b01;
		exp_sel[1] = 2'b11;
		exp_sel[2] = 2'b11;
		exp_sel[3] = 2'b00;
		clear_monitors();
		pkt[0] = 16'h4000;
		pkt[1] = 16'h0002;
		pkt[2] = 16'h0210;
		pkt[3] = {8'h11, 4'b0011, 4'b1110};
		pkt[4] = addr[31:16];
		pkt[5] = addr[15:0];
		for (int i = 0; i < 4; i++) begin
			pkt[6 + i] = 16'h9a00 + 16'(i * 17);
		end
		send_packet(10, 7'h01);
		await_event(EV_WRITES, 4, "four slave writes");
		await_event(EV_CREDIT, 0, "memory write credits");
		check_count("slave writes", 12'(wr_adr.size()), 12'd4);
		for (int i = 0; i < 4 && i < wr_adr.size(); i++) begin
			check_word($sformatf("slv_adr_o write %0d", i), 16'(wr_adr[i] - base), 16'(i));
			check_word($sformatf("slv_dat_o write %0d", i), wr_dat[i], pkt[6 + i]);
			check_bit($sformatf("slv_sel_o[1] write %0d", i), wr_sel[i][1], exp_sel[i][1]);
			check_bit($sformatf("slv_sel_o[0] write %0d", i), wr_sel[i][0], exp_sel[i][0]);
			check_count($sformatf("slv_bar_o write %0d", i), 12'(wr_bar[i]), 12'h001);
		end
		check_count("write start address high bits", 12'(wr_adr[0] >> 8), 12'(base >> 8));
		check_credits(1, 1, 0, 0, 1);
	endtask

	task automatic test_mem_read_3dw();
		logic [31:0] addr;
		addr = 32'h0002_4a74;
		clear_monitors();
		pkt[0] = 16'h0000;
		pkt[1] = 16'h0001;
		pkt[2] = 16'hbeef;
		pkt[3] = {8'h5a, 4'b0000, 4'b0110};
		pkt[4] = addr[31:16];
		pkt[5] = addr[15:0];
		send_packet(6, 7'h02);
		await_event(EV_CREDIT, 0, "memory read credits");
		check_credits(0, 0, 1, 0, 0);
		await_event(EV_TX_DONE, 1, "completion end");
		// Bytes 1 and 2 enabled give count 2 at offset 1
		check_completion(16'hbeef, 8'h5a, 10'd1, 12'd2, {addr[6:2], 2'd1},
			{addr[19:2], 1'b0});
	endtask

	task automatic test_mem_read_stall();
		logic [63:0] addr;
		int          hold;
		addr = 64'h0000_0001_0007_3d28;
		hold = 3 + int'($unsigned($random(seed)) % 8);
		clear_monitors();
		tx_rdy_i = 1'b0;
		pkt[0] = 16'h2000;
		pkt[1] = 16'h0002;
		pkt[2] = 16'h0a0b;
		pkt[3] = {8'hc3, 4'b1111, 4'b1111};
		pkt[4] = addr[63:48];
		pkt[5] = addr[47:32];
		pkt[6] = addr[31:16];
		pkt[7] = addr[15:0];
		send_packet(8, 7'h04);
		await_event(EV_CREDIT, 0, "memory read credits");
		check_credits(0, 0, 1, 0, 0);
		await_event(EV_TX_REQ, 0, "tx_req_o");
		repeat (hold) begin
			@(posedge pcie_clk);
			#DRV;
			check_bit("tx_req_o before grant", tx_req_o, 1'b1);
			check_bit("tx_st_o before grant", tx_st_o, 1'b0);
		end
		tx_rdy_i = 1'b1;
		await_event(EV_TX_DONE, 1, "completion end");
		check_completion(16'h0a0b, 8'hc3, 10'd2, 12'd8, {addr[6:2], 2'd0},
			{addr[19:2], 1'b0});
	endtask

	task automatic test_bar_miss();
		clear_monitors();
		pkt[0] = 16'h4000;
		pkt[1] = 16'h0001;
		pkt[2] = 16'h0330;
		pkt[3] = 16'h220f;
		pkt[4] = 16'h0001;
		pkt[5] = 16'h2340;
		pkt[6] = 16'h5555;
		pkt[7] = 16'haaaa;
		send_packet(8, 7'h0);
		// Window well past the write and credit latency
		repeat (20) @(posedge pcie_clk);
		#DRV;
		check_count("slave writes", 12'(wr_adr.size()), 12'd0);
		check_credits(0, 0, 0, 0, 0);
	endtask

	// ------------------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------------------
	initial begin
		err_cnt = 0;
		seed = 32'h0cd5003a;
		sys_rst = 1'b1;
		rx_st_i = 1'b0;
		rx_end_i = 1'b0;
		rx_data_i = '0;
		rx_bar_hit_i = 7'h0;
		bus_num_i = 8'h03;
		dev_num_i = 5'h1c;
		func_num_i = 3'h5;
		tx_rdy_i = 1'b1;
		slv_dat_i = '0;
		clear_monitors();
		repeat (5) @(posedge pcie_clk);
		#DRV;
		sys_rst = 1'b0;
		test_msg_cfg_credits();
		test_mem_write();
		test_mem_read_3dw();
		test_mem_read_stall();
		test_bar_miss();
		$display("errors: %0d (checks %0d, assertions %0d)",
			err_cnt + i_pcie_tlp.i_pcie_tlp_assertions.fail_cnt, err_cnt,
			i_pcie_tlp.i_pcie_tlp_assertions.fail_cnt);
		if (err_cnt + i_pcie_tlp.i_pcie_tlp_assertions.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the run did not finish in time");
		$display("errors: %0d", err_cnt + 1);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
source/tlp_pkg.sv
source/tlp_rx_if.sv
source/tlp_cpl_if.sv
source/tlp_rx_parser.sv
source/rx_credit_return.sv
source/slave_sequencer.sv
source/cpl_transmitter.sv
source/pcie_tlp.sv
tb/pcie_tlp_assertions.sv
tb/tb_pcie_tlp.sv
